//--- src/CtrlPkg.sv
package CtrlPkg;

	typedef logic [5:0] OpcodeT;
	typedef logic [5:0] FunctT;
	typedef logic [3:0] AluOpT;
	typedef logic [3:0] ByteEnT;
	typedef logic [1:0] RegDstT;
	typedef logic [1:0] RfSrcT;
	typedef logic [1:0] AluSrcBT;
	typedef logic [2:0] PcSrcT;
	typedef logic [4:0] ExCodeT;

	// alu operations
	localparam AluOpT AluPassB = 4'd0;
	localparam AluOpT AluAddu = 4'd1;
	localparam AluOpT AluAdd = 4'd2;
	localparam AluOpT AluSubu = 4'd3;
	localparam AluOpT AluSub = 4'd4;
	localparam AluOpT AluAnd = 4'd5;
	localparam AluOpT AluOr = 4'd6;
	localparam AluOpT AluNor = 4'd7;
	localparam AluOpT AluXor = 4'd8;
	localparam AluOpT AluSltu = 4'd9;
	localparam AluOpT AluSlt = 4'd10;
	localparam AluOpT AluLui = 4'd12;

	localparam ByteEnT ByteEnWord = 4'b1111;
	localparam ByteEnT ByteEnHalf = 4'b0011; // low halfword lanes
	localparam ByteEnT ByteEnNone = 4'b0000;

	localparam RegDstT RegDstRt = 2'd0;
	localparam RegDstT RegDstRd = 2'd1;
	localparam RegDstT RegDstRa = 2'd3; // r31 for jal

	localparam RfSrcT RfSrcAlu = 2'd0;
	localparam RfSrcT RfSrcMdr = 2'd1;
	localparam RfSrcT RfSrcPc = 2'd3;

	localparam AluSrcBT SrcBReg = 2'd0;
	localparam AluSrcBT SrcBFour = 2'd1;
	localparam AluSrcBT SrcBImm = 2'd2;
	localparam AluSrcBT SrcBImmShift = 2'd3;

	localparam PcSrcT PcSrcAlu = 3'd1;
	localparam PcSrcT PcSrcBranch = 3'd2;
	localparam PcSrcT PcSrcJump = 3'd3;
	localparam PcSrcT PcSrcExc = 3'd4;
	localparam PcSrcT PcSrcInt = 3'd5;

	localparam ExCodeT ExcInt = 5'd0;
	localparam ExCodeT ExcIllegal = 5'd10;
	localparam ExCodeT ExcOverflow = 5'd12;

	// opcodes
	localparam OpcodeT OpSpecial = 6'b000000;
	localparam OpcodeT OpLui = 6'b001000;
	localparam OpcodeT OpAddiu = 6'b001001;
	localparam OpcodeT OpAddi = 6'b001010;
	localparam OpcodeT OpAndi = 6'b001011;
	localparam OpcodeT OpOri = 6'b001100;
	localparam OpcodeT OpXori = 6'b001101;
	localparam OpcodeT OpSltiu = 6'b001110;
	localparam OpcodeT OpSlti = 6'b001111;
	localparam OpcodeT OpLh = 6'b100010;
	localparam OpcodeT OpLhu = 6'b100011;
	localparam OpcodeT OpLw = 6'b100100;
	localparam OpcodeT OpSh = 6'b100110;
	localparam OpcodeT OpSw = 6'b100111;
	localparam OpcodeT OpBeq = 6'b110000;
	localparam OpcodeT OpBne = 6'b110101;
	localparam OpcodeT OpJ = 6'b101000;
	localparam OpcodeT OpJal = 6'b101001;
	localparam OpcodeT OpJr = 6'b101010;
	localparam OpcodeT OpJalr = 6'b101011;

	// function codes of the special opcode
	localparam FunctT FnNop = 6'b000000;
	localparam FunctT FnAddu = 6'b000001;
	localparam FunctT FnAdd = 6'b000010;
	localparam FunctT FnSubu = 6'b000011;
	localparam FunctT FnSub = 6'b000100;
	localparam FunctT FnAnd = 6'b000101;
	localparam FunctT FnOr = 6'b000110;
	localparam FunctT FnNor = 6'b000111;
	localparam FunctT FnXor = 6'b001000;
	localparam FunctT FnSltu = 6'b001001;
	localparam FunctT FnSlt = 6'b001010;

	typedef enum logic [2:0] {
		ClsNop,
		ClsReg,
		ClsImm,
		ClsLoad,
		ClsStore,
		ClsBranch,
		ClsJump,
		ClsIllegal
	} InstrClassT;

	typedef enum logic [3:0] {
		StFetch,
		StDecode,
		StMemCalc,
		StMemRead,
		StMemWrite,
		StWriteBack,
		StRegExec,
		StRegWrite,
		StImmExec,
		StImmWrite,
		StBranchEnd,
		StJumpEnd,
		StOvfExc,
		StIllegalExc,
		StIntExc
	} CtrlStateT;

endpackage

//--- src/InstrDecoder.sv
`timescale 1ns/1ns

module InstrDecoder (
	input  CtrlPkg::OpcodeT     Opcode,
	input  CtrlPkg::FunctT      Funct,
	output CtrlPkg::InstrClassT Class,
	output logic                OvfCheck,
	output CtrlPkg::AluOpT      ExecAluOp,
	output CtrlPkg::ByteEnT     ByteEn,
	output logic                MemSigned,
	output logic                BranchOnZero,
	output logic                JumpFromReg,
	output logic                Link,
	output CtrlPkg::RegDstT     LinkDst
);
	import CtrlPkg::*;

	always_comb
	begin
		Class = ClsIllegal; // anything not matched below
		ExecAluOp = AluPassB;
		case (Opcode)
			OpSpecial:
			begin
				Class = ClsReg;
				case (Funct)
					FnNop: Class = ClsNop;
					FnAddu: ExecAluOp = AluAddu;
					FnAdd: ExecAluOp = AluAdd;
					FnSubu: ExecAluOp = AluSubu;
					FnSub: ExecAluOp = AluSub;
					FnAnd: ExecAluOp = AluAnd;
					FnOr: ExecAluOp = AluOr;
					FnNor: ExecAluOp = AluNor;
					FnXor: ExecAluOp = AluXor;
					FnSltu: ExecAluOp = AluSltu;
					FnSlt: ExecAluOp = AluSlt;
					default: Class = ClsIllegal;
				endcase
			end
			OpLui, OpAddiu, OpAddi, OpAndi, OpOri, OpXori, OpSltiu, OpSlti:
			begin
				Class = ClsImm;
				case (Opcode)
					OpLui: ExecAluOp = AluLui;
					OpAddiu: ExecAluOp = AluAddu;
					OpAddi: ExecAluOp = AluAdd;
					OpAndi: ExecAluOp = AluAnd;
					OpOri: ExecAluOp = AluOr;
					OpXori: ExecAluOp = AluXor;
					OpSltiu: ExecAluOp = AluSltu;
					default: ExecAluOp = AluSlt; // slti
				endcase
			end
			OpLw, OpLh, OpLhu: Class = ClsLoad;
			OpSw, OpSh: Class = ClsStore;
			OpBeq, OpBne: Class = ClsBranch;
			OpJ, OpJal, OpJr, OpJalr: Class = ClsJump;
			default: Class = ClsIllegal;
		endcase
	end

	// only the signed forms trap on overflow
	assign OvfCheck = (Opcode == OpAddi) ||
		(Opcode == OpSpecial && (Funct == FnAdd || Funct == FnSub));

	assign ByteEn = (Opcode == OpLh || Opcode == OpLhu || Opcode == OpSh) ? ByteEnHalf : ByteEnWord;
	assign MemSigned = (Opcode == OpLh);
	assign BranchOnZero = (Opcode == OpBeq); // bne takes the other sense

	assign JumpFromReg = (Opcode == OpJr) || (Opcode == OpJalr);
	assign Link = (Opcode == OpJal) || (Opcode == OpJalr);
	assign LinkDst = (Opcode == OpJal) ? RegDstRa : RegDstRd;

endmodule

//--- src/MainFsm.sv
`timescale 1ns/1ns

module MainFsm (
	input  logic                PClk,
	input  logic                Reset,
	input  CtrlPkg::InstrClassT Class,
	input  logic                OvfCheck,
	input  logic                AluOverflow,
	input  logic                MemDataReady,
	input  logic                ExtInt,
	input  logic                IE,
	output CtrlPkg::CtrlStateT  State
);
	import CtrlPkg::*;

	CtrlStateT nextState;
	logic intReq;
	logic ovfTrap;

	assign intReq = ExtInt && IE;
	assign ovfTrap = AluOverflow && OvfCheck;

	always_ff @(posedge PClk or posedge Reset)
	begin
		if (Reset)
			State <= StFetch;
		else
			State <= nextState;
	end

	always_comb
	begin
		nextState = State; // memory states hold by default
		case (State)
			StFetch:
				if (MemDataReady)
					nextState = StDecode;
			StDecode:
				case (Class)
					ClsNop: nextState = StFetch;
					ClsReg: nextState = StRegExec;
					ClsImm: nextState = StImmExec;
					ClsLoad, ClsStore: nextState = StMemCalc;
					ClsBranch: nextState = StBranchEnd;
					ClsJump: nextState = StJumpEnd;
					default: nextState = StIllegalExc;
				endcase
			StMemCalc:
				nextState = (Class == ClsStore) ? StMemWrite : StMemRead;
			StMemRead:
				if (MemDataReady)
					nextState = StWriteBack;
			StMemWrite:
				if (MemDataReady)
					nextState = StFetch;
			StWriteBack:
				nextState = StFetch;
			// overflow wins over the write state
			StRegExec:
				nextState = ovfTrap ? StOvfExc : StRegWrite;
			StImmExec:
				nextState = ovfTrap ? StOvfExc : StImmWrite;
			StRegWrite, StImmWrite, StBranchEnd, StJumpEnd:
				nextState = intReq ? StIntExc : StFetch; // interrupts only taken here
			default:
				nextState = StFetch; // exception states and unused codes
		endcase
	end

endmodule

//--- src/DatapathCtrl.sv
`timescale 1ns/1ns

module DatapathCtrl (
	input  CtrlPkg::CtrlStateT State,
	input  logic               AluZero,
	input  CtrlPkg::AluOpT     ExecAluOp,
	input  CtrlPkg::ByteEnT    ByteEn,
	input  logic               MemSigned,
	input  logic               BranchOnZero,
	input  logic               JumpFromReg,
	input  logic               Link,
	input  CtrlPkg::RegDstT    LinkDst,
	output logic               PCWrite,
	output logic               IRWrite,
	output logic               MemWrite,
	output logic               MemSign,
	output CtrlPkg::ByteEnT    ByteEnable,
	output logic               IorD,
	output logic               RegWrite,
	output CtrlPkg::RegDstT    RegDst,
	output CtrlPkg::RfSrcT     RfSource,
	output CtrlPkg::AluOpT     AluOp,
	output logic               AluSrcA,
	output CtrlPkg::AluSrcBT   AluSrcB,
	output CtrlPkg::PcSrcT     PCSource,
	output logic               CP0Write,
	output logic               Exception,
	output CtrlPkg::ExCodeT    ExCode
);
	import CtrlPkg::*;

	always_comb
	begin
		PCWrite = 1'b0;
		IRWrite = 1'b0;
		MemWrite = 1'b0;
		MemSign = 1'b0;
		ByteEnable = ByteEnNone;
		IorD = 1'b0;
		RegWrite = 1'b0;
		RegDst = RegDstRt;
		RfSource = RfSrcAlu;
		AluOp = AluPassB;
		AluSrcA = 1'b0;
		AluSrcB = SrcBReg;
		PCSource = '0;
		CP0Write = 1'b0;
		Exception = 1'b0;
		ExCode = ExcInt;
		case (State)
			StFetch:
			begin
				IRWrite = 1'b1;
				PCWrite = 1'b1;
				ByteEnable = ByteEnWord;
				AluOp = AluAddu; // pc + 4
				AluSrcB = SrcBFour;
				PCSource = PcSrcAlu;
			end
			StDecode:
			begin
				AluOp = AluAdd; // branch target ahead of time
				AluSrcB = SrcBImmShift;
			end
			StMemCalc:
			begin
				AluOp = AluAdd;
				AluSrcA = 1'b1;
				AluSrcB = SrcBImm;
			end
			StMemRead, StMemWrite:
			begin
				IorD = 1'b1;
				ByteEnable = ByteEn;
				MemSign = MemSigned;
				MemWrite = (State == StMemWrite);
			end
			StWriteBack:
			begin
				RegWrite = 1'b1;
				RfSource = RfSrcMdr;
			end
			StRegExec, StImmExec:
			begin
				AluOp = ExecAluOp;
				AluSrcA = 1'b1;
				AluSrcB = (State == StImmExec) ? SrcBImm : SrcBReg;
			end
			StRegWrite:
			begin
				RegWrite = 1'b1;
				RegDst = RegDstRd;
			end
			StImmWrite: RegWrite = 1'b1;
			StBranchEnd:
			begin
				AluOp = AluSubu; // compare rs and rt
				AluSrcA = 1'b1;
				PCSource = PcSrcBranch;
				PCWrite = (AluZero == BranchOnZero);
			end
			StJumpEnd:
			begin
				PCWrite = 1'b1;
				RegWrite = Link;
				RegDst = Link ? LinkDst : RegDstRt;
				RfSource = Link ? RfSrcPc : RfSrcAlu;
				PCSource = JumpFromReg ? PcSrcAlu : PcSrcJump; // register target passes through alu
			end
			StOvfExc, StIllegalExc, StIntExc:
			begin
				PCWrite = 1'b1;
				CP0Write = 1'b1;
				Exception = 1'b1;
				PCSource = (State == StIntExc) ? PcSrcInt : PcSrcExc;
				if (State == StOvfExc)
					ExCode = ExcOverflow;
				else if (State == StIllegalExc)
					ExCode = ExcIllegal;
			end
			default: ;
		endcase
	end

endmodule

//--- src/Controller.sv
`timescale 1ns/1ns

module Controller (
	input  logic             PClk,
	input  logic             Reset,
	input  CtrlPkg::OpcodeT  Opcode,
	input  CtrlPkg::FunctT   Funct,
	input  logic             AluZero,
	input  logic             AluOverflow,
	input  logic             MemDataReady,
	input  logic             ExtInt,
	input  logic             IE,
	output logic             PCWrite,
	output logic             IRWrite,
	output logic             MemWrite,
	output logic             MemSign,
	output CtrlPkg::ByteEnT  ByteEnable,
	output logic             IorD,
	output logic             RegWrite,
	output CtrlPkg::RegDstT  RegDst,
	output CtrlPkg::RfSrcT   RfSource,
	output CtrlPkg::AluOpT   AluOp,
	output logic             AluSrcA,
	output CtrlPkg::AluSrcBT AluSrcB,
	output CtrlPkg::PcSrcT   PCSource,
	output logic             CP0Write,
	output logic             Exception,
	output CtrlPkg::ExCodeT  ExCode
);
	import CtrlPkg::*;

	InstrClassT instrClass;
	CtrlStateT state;
	AluOpT execAluOp;
	ByteEnT byteEn;
	RegDstT linkDst;
	logic ovfCheck;
	logic memSigned;
	logic branchOnZero;
	logic jumpFromReg;
	logic link;

	InstrDecoder decoder (
		.Opcode(Opcode),
		.Funct(Funct),
		.Class(instrClass),
		.OvfCheck(ovfCheck),
		.ExecAluOp(execAluOp),
		.ByteEn(byteEn),
		.MemSigned(memSigned),
		.BranchOnZero(branchOnZero),
		.JumpFromReg(jumpFromReg),
		.Link(link),
		.LinkDst(linkDst)
	);

	MainFsm fsm (
		.PClk(PClk),
		.Reset(Reset),
		.Class(instrClass),
		.OvfCheck(ovfCheck),
		.AluOverflow(AluOverflow),
		.MemDataReady(MemDataReady),
		.ExtInt(ExtInt),
		.IE(IE),
		.State(state)
	);

	DatapathCtrl outputs (
		.State(state),
		.AluZero(AluZero),
		.ExecAluOp(execAluOp),
		.ByteEn(byteEn),
		.MemSigned(memSigned),
		.BranchOnZero(branchOnZero),
		.JumpFromReg(jumpFromReg),
		.Link(link),
		.LinkDst(linkDst),
		.PCWrite(PCWrite),
		.IRWrite(IRWrite),
		.MemWrite(MemWrite),
		.MemSign(MemSign),
		.ByteEnable(ByteEnable),
		.IorD(IorD),
		.RegWrite(RegWrite),
		.RegDst(RegDst),
		.RfSource(RfSource),
		.AluOp(AluOp),
		.AluSrcA(AluSrcA),
		.AluSrcB(AluSrcB),
		.PCSource(PCSource),
		.CP0Write(CP0Write),
		.Exception(Exception),
		.ExCode(ExCode)
	);

endmodule

//--- verif/Controller_chk.sv
`timescale 1ns/1ns

module ControllerChk (
	input logic               PClk,
	input logic               Reset,
	input CtrlPkg::CtrlStateT State,
	input logic               IRWrite,
	input logic               MemWrite,
	input logic               IorD,
	input logic               Exception,
	input logic               PCWrite,
	input logic               CP0Write
);
	import CtrlPkg::*;

	int failCount = 0; // assertion failures so far

	// stores always address data memory
	StoreUsesDataAddr: assert property (@(posedge PClk) disable iff (Reset) MemWrite |-> IorD)
	else
	begin
		failCount++;
		$error("MemWrite asserted without IorD");
	end

	ExcWritesPcAndCp0: assert property (@(posedge PClk) disable iff (Reset)
		Exception |-> (PCWrite && CP0Write))
	else
	begin
		failCount++;
		$error("Exception asserted without PCWrite and CP0Write");
	end

	IrOnlyInFetch: assert property (@(posedge PClk) disable iff (Reset)
		IRWrite |-> (State == StFetch))
	else
	begin
		failCount++;
		$error("IRWrite asserted outside the fetch state");
	end

endmodule

bind Controller ControllerChk chk (
	.PClk(PClk),
	.Reset(Reset),
	.State(state),
	.IRWrite(IRWrite),
	.MemWrite(MemWrite),
	.IorD(IorD),
	.Exception(Exception),
	.PCWrite(PCWrite),
	.CP0Write(CP0Write)
);

//--- verif/ControllerMonitor.sv
`timescale 1ns/1ns

module ControllerMonitor (
	input  logic             PClk,
	input  logic             Reset,
	input  CtrlPkg::OpcodeT  Opcode,
	input  CtrlPkg::FunctT   Funct,
	input  logic             AluZero,
	input  logic             AluOverflow,
	input  logic             MemDataReady,
	input  logic             ExtInt,
	input  logic             IE,
	input  logic             PCWrite,
	input  logic             IRWrite,
	input  logic             MemWrite,
	input  logic             MemSign,
	input  CtrlPkg::ByteEnT  ByteEnable,
	input  logic             IorD,
	input  logic             RegWrite,
	input  CtrlPkg::RegDstT  RegDst,
	input  CtrlPkg::RfSrcT   RfSource,
	input  CtrlPkg::AluOpT   AluOp,
	input  logic             AluSrcA,
	input  CtrlPkg::AluSrcBT AluSrcB,
	input  CtrlPkg::PcSrcT   PCSource,
	input  logic             CP0Write,
	input  logic             Exception,
	input  CtrlPkg::ExCodeT  ExCode,
	input  logic             RunDone,
	output int               ErrorCount,
	output int               CheckCount,
	output logic             ReportDone
);
	import CtrlPkg::*;

	CtrlStateT modelState;
	int testChecks [5];
	int testErrors [5];
	string testNames [5];

	initial
	begin
		testNames = '{"fetch and decode", "register and immediate ops", "loads and stores",
			"branches and jumps", "exceptions and interrupts"};
		testChecks = '{default: 0};
		testErrors = '{default: 0};
		ErrorCount = 0;
		CheckCount = 0;
		ReportDone = 1'b0;
		modelState = StFetch;
	end

	function automatic InstrClassT classOf(OpcodeT op, FunctT fn);
		InstrClassT cls;
		cls = ClsIllegal;
		if (op == OpSpecial)
			cls = (fn == FnNop) ? ClsNop : ((fn <= FnSlt) ? ClsReg : ClsIllegal);
		else if (op[5:3] == 3'b001)
			cls = ClsImm; // 001xxx are all immediate ops
		else if (op == OpLw || op == OpLh || op == OpLhu)
			cls = ClsLoad;
		else if (op == OpSw || op == OpSh)
			cls = ClsStore;
		else if (op == OpBeq || op == OpBne)
			cls = ClsBranch;
		else if (op[5:2] == 4'b1010)
			cls = ClsJump;
		return cls;
	endfunction

	function automatic AluOpT execOpOf(OpcodeT op, FunctT fn);
		AluOpT immOps [8];
		immOps = '{AluLui, AluAddu, AluAdd, AluAnd, AluOr, AluXor, AluSltu, AluSlt};
		if (op == OpSpecial)
			return AluOpT'(fn[3:0]); // function codes share the alu numbering
		return immOps[op[2:0]];
	endfunction

	function automatic logic ovfOf(OpcodeT op, FunctT fn);
		return (op == OpAddi) || (op == OpSpecial && (fn == FnAdd || fn == FnSub));
	endfunction

	function automatic int testOf(CtrlStateT st);
		int idx;
		case (st)
			StFetch, StDecode: idx = 0;
			StRegExec, StRegWrite, StImmExec, StImmWrite: idx = 1;
			StMemCalc, StMemRead, StMemWrite, StWriteBack: idx = 2;
			StBranchEnd, StJumpEnd: idx = 3;
			default: idx = 4;
		endcase
		return idx;
	endfunction

	function automatic CtrlStateT nextOf(CtrlStateT st);
		InstrClassT cls;
		CtrlStateT nxt;
		cls = classOf(Opcode, Funct);
		nxt = StFetch; // writeback and exception states
		case (st)
			StFetch: nxt = MemDataReady ? StDecode : StFetch;
			StDecode:
				case (cls)
					ClsNop: nxt = StFetch;
					ClsReg: nxt = StRegExec;
					ClsImm: nxt = StImmExec;
					ClsLoad, ClsStore: nxt = StMemCalc;
					ClsBranch: nxt = StBranchEnd;
					ClsJump: nxt = StJumpEnd;
					default: nxt = StIllegalExc;
				endcase
			StMemCalc: nxt = (cls == ClsStore) ? StMemWrite : StMemRead;
			StMemRead: nxt = MemDataReady ? StWriteBack : StMemRead;
			StMemWrite: nxt = MemDataReady ? StFetch : StMemWrite;
			StRegExec: nxt = (AluOverflow && ovfOf(Opcode, Funct)) ? StOvfExc : StRegWrite;
			StImmExec: nxt = (AluOverflow && ovfOf(Opcode, Funct)) ? StOvfExc : StImmWrite;
			StRegWrite, StImmWrite, StBranchEnd, StJumpEnd:
				nxt = (ExtInt && IE) ? StIntExc : StFetch;
			default: nxt = StFetch;
		endcase
		return nxt;
	endfunction

	task automatic checkField(string name, logic [31:0] expVal, logic [31:0] actVal, int idx);
		testChecks[idx]++;
		CheckCount++;
		if (expVal !== actVal)
		begin
			testErrors[idx]++;
			ErrorCount++;
			$display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkCycle();
		int idx;
		logic pcWr;
		logic irWr;
		logic memWr;
		logic memSg;
		logic iorD;
		logic regWr;
		logic srcA;
		logic cp0Wr;
		logic exc;
		ByteEnT be;
		RegDstT dst;
		RfSrcT rfSrc;
		AluOpT op;
		AluSrcBT srcB;
		PcSrcT pcSrc;
		ExCodeT code;
		idx = testOf(modelState);
		pcWr = 1'b0;
		irWr = 1'b0;
		memWr = 1'b0;
		memSg = 1'b0;
		iorD = 1'b0;
		regWr = 1'b0;
		srcA = 1'b0;
		cp0Wr = 1'b0;
		exc = 1'b0;
		be = ByteEnNone;
		dst = RegDstRt;
		rfSrc = RfSrcAlu;
		op = AluPassB;
		srcB = SrcBReg;
		pcSrc = '0;
		code = ExcInt;
		case (modelState)
			StFetch:
			begin
				irWr = 1'b1;
				pcWr = 1'b1;
				be = ByteEnWord;
				op = AluAddu;
				srcB = SrcBFour;
				pcSrc = PcSrcAlu;
			end
			StDecode:
			begin
				op = AluAdd;
				srcB = SrcBImmShift;
			end
			StMemCalc:
			begin
				op = AluAdd;
				srcA = 1'b1;
				srcB = SrcBImm;
			end
			StMemRead, StMemWrite:
			begin
				iorD = 1'b1;
				be = (Opcode == OpLh || Opcode == OpLhu || Opcode == OpSh) ? ByteEnHalf : ByteEnWord;
				memSg = (Opcode == OpLh);
				memWr = (modelState == StMemWrite);
			end
			StWriteBack:
			begin
				regWr = 1'b1;
				rfSrc = RfSrcMdr;
			end
			StRegExec, StImmExec:
			begin
				op = execOpOf(Opcode, Funct);
				srcA = 1'b1;
				if (modelState == StImmExec)
					srcB = SrcBImm;
			end
			StRegWrite:
			begin
				regWr = 1'b1;
				dst = RegDstRd;
			end
			StImmWrite:
				regWr = 1'b1;
			StBranchEnd:
			begin
				op = AluSubu;
				srcA = 1'b1;
				pcSrc = PcSrcBranch;
				pcWr = AluZero == (Opcode == OpBeq); // bne takes when not zero
			end
			StJumpEnd:
			begin
				pcWr = 1'b1;
				pcSrc = (Opcode == OpJr || Opcode == OpJalr) ? PcSrcAlu : PcSrcJump;
				if (Opcode == OpJal || Opcode == OpJalr)
				begin
					regWr = 1'b1;
					dst = (Opcode == OpJal) ? RegDstRa : RegDstRd;
					rfSrc = RfSrcPc;
				end
			end
			default:
			begin
				pcWr = 1'b1;
				cp0Wr = 1'b1;
				exc = 1'b1;
				pcSrc = (modelState == StIntExc) ? PcSrcInt : PcSrcExc;
				if (modelState == StOvfExc)
					code = ExcOverflow;
				else if (modelState == StIllegalExc)
					code = ExcIllegal;
			end
		endcase
		checkField("PCWrite", 32'(pcWr), 32'(PCWrite), idx);
		checkField("IRWrite", 32'(irWr), 32'(IRWrite), idx);
		checkField("MemWrite", 32'(memWr), 32'(MemWrite), idx);
		checkField("MemSign", 32'(memSg), 32'(MemSign), idx);
		checkField("ByteEnable", 32'(be), 32'(ByteEnable), idx);
		checkField("IorD", 32'(iorD), 32'(IorD), idx);
		checkField("RegWrite", 32'(regWr), 32'(RegWrite), idx);
		checkField("RegDst", 32'(dst), 32'(RegDst), idx);
		checkField("RfSource", 32'(rfSrc), 32'(RfSource), idx);
		checkField("AluOp", 32'(op), 32'(AluOp), idx);
		checkField("AluSrcA", 32'(srcA), 32'(AluSrcA), idx);
		checkField("AluSrcB", 32'(srcB), 32'(AluSrcB), idx);
		checkField("PCSource", 32'(pcSrc), 32'(PCSource), idx);
		checkField("CP0Write", 32'(cp0Wr), 32'(CP0Write), idx);
		checkField("Exception", 32'(exc), 32'(Exception), idx);
		checkField("ExCode", 32'(code), 32'(ExCode), idx);
	endtask

	// outputs settle after the rising edge, inputs hold until the next one
	always @(negedge PClk)
	begin
		if (Reset)
			modelState = StFetch;
		else if (!RunDone)
		begin
			checkCycle();
			modelState = nextOf(modelState);
		end
	end

	always @(posedge RunDone)
	begin
		for (int i = 0; i < 5; i++)
			$display("test %0d %s: %0d checks, %0d errors", i + 1, testNames[i],
				testChecks[i], testErrors[i]);
		ReportDone = 1'b1;
	end

endmodule

//--- verif/ControllerTb.sv
`timescale 1ns/1ns

module ControllerTb;
	import CtrlPkg::*;

	localparam int InstrTarget = 800;
	localparam int CycleLimit = 40000;

	logic PClk;
	logic Reset;
	OpcodeT Opcode;
	FunctT Funct;
	logic AluZero;
	logic AluOverflow;
	logic MemDataReady;
	logic ExtInt;
	logic IE;
	logic PCWrite;
	logic IRWrite;
	logic MemWrite;
	logic MemSign;
	ByteEnT ByteEnable;
	logic IorD;
	logic RegWrite;
	RegDstT RegDst;
	RfSrcT RfSource;
	AluOpT AluOp;
	logic AluSrcA;
	AluSrcBT AluSrcB;
	PcSrcT PCSource;
	logic CP0Write;
	logic Exception;
	ExCodeT ExCode;
	logic RunDone;
	int ErrorCount;
	int CheckCount;
	logic ReportDone;
	int seed;
	int fetched;
	int waitCycles;

	Controller UUT (.*);

	ControllerMonitor monitor (.*);

	initial
	begin
		PClk = 1'b0;
		forever
			#2 PClk = ~PClk;
	end

	// weighted mix with funct bits random where the opcode ignores them
	task automatic pickInstr();
		int r;
		r = {$random(seed)} % 100;
		Funct <= FunctT'($random(seed));
		if (r < 8)
		begin
			Opcode <= OpSpecial;
			Funct <= FnNop;
		end
		else if (r < 35)
		begin
			Opcode <= OpSpecial;
			Funct <= FunctT'(1 + {$random(seed)} % 10);
		end
		else if (r < 55)
			Opcode <= OpcodeT'(OpLui + {$random(seed)} % 8);
		else if (r < 68)
		begin
			case ({$random(seed)} % 3)
				0: Opcode <= OpLw;
				1: Opcode <= OpLh;
				default: Opcode <= OpLhu;
			endcase
		end
		else if (r < 78)
			Opcode <= ({$random(seed)} % 2 == 0) ? OpSw : OpSh;
		else if (r < 86)
			Opcode <= ({$random(seed)} % 2 == 0) ? OpBeq : OpBne;
		else if (r < 94)
			Opcode <= OpcodeT'(OpJ + {$random(seed)} % 4);
		else if (r % 2 == 0)
		begin
			Opcode <= OpSpecial;
			Funct <= FunctT'(11 + {$random(seed)} % 53); // unused function codes
		end
		else
			Opcode <= OpcodeT'(56 + {$random(seed)} % 8); // 111xxx is unused
	endtask

	always @(posedge PClk)
	begin
		MemDataReady <= ({$random(seed)} % 4) != 0;
		AluZero <= ({$random(seed)} % 2) == 1;
		AluOverflow <= ({$random(seed)} % 5) == 0;
		ExtInt <= ({$random(seed)} % 4) == 0;
		IE <= ({$random(seed)} % 2) == 1;
		if (!Reset && IRWrite && MemDataReady)
		begin
			fetched <= fetched + 1; // instruction register loads now
			pickInstr();
		end
	end

	initial
	begin
		seed = 66580;
		Reset = 1'b1;
		Opcode = OpSpecial;
		Funct = FnNop;
		AluZero = 1'b0;
		AluOverflow = 1'b0;
		MemDataReady = 1'b0;
		ExtInt = 1'b0;
		IE = 1'b0;
		RunDone = 1'b0;
		fetched = 0;
		repeat (2)
			@(posedge PClk);
		Reset <= 1'b0;
		waitCycles = 0;
		while (fetched < InstrTarget && waitCycles < CycleLimit)
		begin
			@(posedge PClk);
			waitCycles++;
		end
		if (fetched < InstrTarget)
			$display("timeout: only %0d of %0d instructions fetched in %0d cycles",
				fetched, InstrTarget, waitCycles);
		else
		begin
			RunDone <= 1'b1;
			waitCycles = 0;
			while (!ReportDone && waitCycles < 10)
			begin
				#1;
				waitCycles++;
			end
			if (!ReportDone)
				$display("monitor did not report its per-test summary");
		end
		$display("%0d instructions, %0d checks, %0d errors, %0d assertion failures",
			fetched, CheckCount, ErrorCount, UUT.chk.failCount);
		if (ReportDone && ErrorCount == 0 && CheckCount > 0 && UUT.chk.failCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- MipsCtrl.f
src/CtrlPkg.sv
src/InstrDecoder.sv
src/MainFsm.sv
src/DatapathCtrl.sv
src/Controller.sv
verif/Controller_chk.sv
verif/ControllerMonitor.sv
verif/ControllerTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = ControllerTb
FILELIST  = MipsCtrl.f
OBJDIR    = obj_dir
SIMARGS   = +verilator+error+limit+100
PASSMSG   = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
